// ==== hdl/rvPkg.sv ====
// shared types for the pipelined RV32I subset core
// word-only memory access; no CSRs, traps or M extension
package rvPkg;

	// architectural register count and first fetch address
	localparam int          NumRegs  = 32;
	localparam logic [31:0] ResetPc  = 32'h0000_0000;
	// addi x0, x0, 0 used as the fetch bubble
	localparam logic [31:0] NopInstr = 32'h0000_0013;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OpLui    = 7'b0110111,
		OpAuipc  = 7'b0010111,
		OpJal    = 7'b1101111,
		OpJalr   = 7'b1100111,
		OpBranch = 7'b1100011,
		OpLoad   = 7'b0000011,
		OpStore  = 7'b0100011,
		OpOpImm  = 7'b0010011,
		OpOp     = 7'b0110011
	} opcodeT;

	// alu functions, passB serves LUI
	typedef enum logic [3:0] {
		AluAdd, AluSub, AluSlt, AluXor, AluOr,
		AluAnd, AluSll, AluSrl, AluSra, AluPassB
	} aluOpT;

	// execute operand source
	typedef enum logic [1:0] {
		FwdReg, FwdMem, FwdWb
	} fwdSelT;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] pcPlus4;
	} ifIdT;

	typedef struct packed {
		logic        regWrite;
		logic        memToReg;
		logic        memWrite;
		logic        aluSrcImm;
		// pc as operand A, AUIPC only
		logic        pcSrcA;
		// JAL/JALR write pcPlus4
		logic        link;
		aluOpT       aluOp;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] rs1Data;
		logic [31:0] rs2Data;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] pcPlus4;
	} idExT;

	typedef struct packed {
		logic        regWrite;
		logic        memToReg;
		logic        memWrite;
		logic [4:0]  rd;
		logic [31:0] aluOut;
		logic [31:0] storeData;
	} exMemT;

	typedef struct packed {
		logic        regWrite;
		logic        memToReg;
		logic [4:0]  rd;
		logic [31:0] aluOut;
		logic [31:0] readData;
	} memWbT;

endpackage

// ==== hdl/fetchStage.sv ====
// instruction memory must answer combinationally in the same cycle
// stall wins over redirect; decode gates redirect while stalled anyway
`timescale 1ns/1ps

module fetchStage (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  logic        redirect,
	input  logic [31:0] redirectPc,
	input  logic [31:0] imemData,
	output logic [31:0] imemAddr,
	output rvPkg::ifIdT ifId
);
	import rvPkg::*;

	logic [31:0] pc;
	logic [31:0] pcPlus4;

	assign pcPlus4  = pc + 32'd4;
	assign imemAddr = pc;

	// next pc: taken branch/jump target or sequential
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= ResetPc;
		end else if (!stall) begin
			pc <= redirect ? redirectPc : pcPlus4;
		end
	end

	// fetch-to-decode register, nop on flush
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ifId.instr <= NopInstr;
		end else if (!stall) begin
			ifId <= '{instr: imemData, pc: pc, pcPlus4: pcPlus4};
		end
	end

	// targets from decode must keep the pc on a word boundary
	pcAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
		else $error("fetch address %h not word aligned", imemAddr);

endmodule

// ==== hdl/decodeStage.sv ====
// branches and jumps resolve here; one slot is flushed on redirect
// register file writes on the falling edge so decode sees writeback data
`timescale 1ns/1ps

module decodeStage (
	input  logic         clk,
	input  logic         rst,
	input  rvPkg::ifIdT  ifId,
	input  logic         stall,
	input  logic         flush,
	input  logic         fwdDecA,
	input  logic         fwdDecB,
	input  logic [31:0]  exMemAluOut,
	input  rvPkg::memWbT memWb,
	input  logic [31:0]  wbResult,
	output logic [4:0]   rs1,
	output logic [4:0]   rs2,
	output logic         usesBranchOperands,
	output logic         redirect,
	output logic [31:0]  redirectPc,
	output rvPkg::idExT  idEx
);
	import rvPkg::*;

	logic [31:0] regs [NumRegs];
	logic [31:0] instr;
	opcodeT      op;
	logic [2:0]  funct3;
	logic [31:0] immI, immS, immB, immU, immJ;
	logic [31:0] rf1, rf2, opA, opB;
	logic        usesRs1, usesRs2, taken;
	idExT        idExNext;

	// funct3/funct7 to alu function, alt is instr[30] where it matters
	function automatic aluOpT aluFunc(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? AluSub : AluAdd;
			3'b001:  return AluSll;
			3'b010:  return AluSlt;
			3'b100:  return AluXor;
			3'b101:  return alt ? AluSra : AluSrl;
			3'b110:  return AluOr;
			default: return AluAnd;
		endcase
	endfunction

	assign instr  = ifId.instr;
	assign op     = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];

	// immediate formats
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'd0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// unused source fields read as x0 so no false hazards
	assign usesRs1 = op inside {OpJalr, OpBranch, OpLoad, OpStore, OpOpImm, OpOp};
	assign usesRs2 = op inside {OpBranch, OpStore, OpOp};
	assign rs1 = usesRs1 ? instr[19:15] : 5'd0;
	assign rs2 = usesRs2 ? instr[24:20] : 5'd0;
	assign usesBranchOperands = op inside {OpBranch, OpJalr};

	// x0 never written
	always_ff @(negedge clk) begin
		if (memWb.regWrite && memWb.rd != 5'd0) begin
			regs[memWb.rd] <= wbResult;
		end
	end

	assign rf1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rf2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
	// memory-stage alu result for the compare
	assign opA = fwdDecA ? exMemAluOut : rf1;
	assign opB = fwdDecB ? exMemAluOut : rf2;

	// only beq/bne among branches
	always_comb begin
		case (op)
			OpBranch:     taken = (funct3 == 3'b000) ? (opA == opB)
				: (funct3 == 3'b001) && (opA != opB);
			OpJal, OpJalr: taken = 1'b1;
			default:      taken = 1'b0;
		endcase
	end

	// stale operands while stalled, so hold off
	assign redirect   = taken && !stall;
	assign redirectPc = (op == OpJalr) ? ((opA + immI) & ~32'd1)
		: ifId.pc + ((op == OpJal) ? immJ : immB);

	// control decode, anything unknown stays a bubble
	always_comb begin
		idExNext         = '0;
		idExNext.aluOp   = AluAdd;
		idExNext.rs1     = rs1;
		idExNext.rs2     = rs2;
		idExNext.rd      = instr[11:7];
		idExNext.rs1Data = opA;
		idExNext.rs2Data = opB;
		idExNext.imm     = immI;
		idExNext.pc      = ifId.pc;
		idExNext.pcPlus4 = ifId.pcPlus4;
		case (op)
			OpLui, OpAuipc: begin
				idExNext.regWrite  = 1'b1;
				idExNext.aluSrcImm = 1'b1;
				idExNext.imm       = immU;
				idExNext.pcSrcA    = (op == OpAuipc);
				idExNext.aluOp     = (op == OpLui) ? AluPassB : AluAdd;
			end
			OpJal, OpJalr: begin
				idExNext.regWrite = 1'b1;
				idExNext.link     = 1'b1;
			end
			OpLoad: begin
				idExNext.regWrite  = 1'b1;
				idExNext.memToReg  = 1'b1;
				idExNext.aluSrcImm = 1'b1;
			end
			OpStore: begin
				idExNext.memWrite  = 1'b1;
				idExNext.aluSrcImm = 1'b1;
				idExNext.imm       = immS;
			end
			OpOpImm, OpOp: begin
				// sltu/sltiu not in the subset
				idExNext.regWrite  = (funct3 != 3'b011);
				idExNext.aluSrcImm = (op == OpOpImm);
				idExNext.aluOp     = aluFunc(funct3,
					instr[30] && (op == OpOp || funct3 == 3'b101));
			end
			default: ;
		endcase
	end

	// decode-to-execute register, bubble on flush
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			idEx.regWrite <= 1'b0;
			idEx.memToReg <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.link     <= 1'b0;
		end else begin
			idEx <= idExNext;
		end
	end

	// byte and halfword accesses are outside the subset
	wordAccess: assert property (@(posedge clk) disable iff (rst)
		(op inside {OpLoad, OpStore}) |-> funct3 == 3'b010)
		else $error("non-word memory access at pc %h", ifId.pc);

endmodule

// ==== hdl/executeStage.sv ====
// operand forwarding from memory and writeback, then the alu
// shifts use the low five bits of operand B
`timescale 1ns/1ps

module executeStage (
	input  logic           clk,
	input  logic           rst,
	input  rvPkg::idExT    idEx,
	input  rvPkg::fwdSelT  fwdA,
	input  rvPkg::fwdSelT  fwdB,
	input  logic [31:0]    wbResult,
	output rvPkg::exMemT   exMem
);
	import rvPkg::*;

	logic [31:0] fwdValA, fwdValB;
	logic [31:0] srcA, srcB;
	logic [31:0] aluOut;
	exMemT       exNext;

	function automatic logic [31:0] pickOperand(input fwdSelT sel,
		input logic [31:0] regVal, input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			FwdMem:  return memVal;
			FwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	// newest value of each source register
	assign fwdValA = pickOperand(fwdA, idEx.rs1Data, exMem.aluOut, wbResult);
	assign fwdValB = pickOperand(fwdB, idEx.rs2Data, exMem.aluOut, wbResult);

	// pc for auipc, immediate for I/S/U forms
	assign srcA = idEx.pcSrcA ? idEx.pc : fwdValA;
	assign srcB = idEx.aluSrcImm ? idEx.imm : fwdValB;

	always_comb begin
		case (idEx.aluOp)
			AluSub:   aluOut = srcA - srcB;
			AluSlt:   aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			AluXor:   aluOut = srcA ^ srcB;
			AluOr:    aluOut = srcA | srcB;
			AluAnd:   aluOut = srcA & srcB;
			AluSll:   aluOut = srcA << srcB[4:0];
			AluSrl:   aluOut = srcA >> srcB[4:0];
			AluSra:   aluOut = $unsigned($signed(srcA) >>> srcB[4:0]);
			AluPassB: aluOut = srcB;
			default:  aluOut = srcA + srcB;
		endcase
	end

	// link result replaces the alu for jal/jalr
	assign exNext = '{regWrite: idEx.regWrite, memToReg: idEx.memToReg,
		memWrite: idEx.memWrite, rd: idEx.rd,
		aluOut: idEx.link ? idEx.pcPlus4 : aluOut, storeData: fwdValB};

	always_ff @(posedge clk) begin
		if (rst) begin
			exMem.regWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem <= exNext;
		end
	end

endmodule

// ==== hdl/memoryStage.sv ====
// data memory answers in the same cycle, no wait states
// wbResult is the writeback-stage value used by decode and execute
`timescale 1ns/1ps

module memoryStage (
	input  logic         clk,
	input  logic         rst,
	input  rvPkg::exMemT exMem,
	input  logic [31:0]  dmemRd,
	output logic         dmemWe,
	output logic [31:0]  dmemAddr,
	output logic [31:0]  dmemWd,
	output rvPkg::memWbT memWb,
	output logic [31:0]  wbResult
);

	// data port straight from the ex/mem register
	assign dmemWe   = exMem.memWrite;
	assign dmemAddr = exMem.aluOut;
	assign dmemWd   = exMem.storeData;

	// memory-to-writeback register
	always_ff @(posedge clk) begin
		if (rst) begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
		end else begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		memWb.rd       <= exMem.rd;
		memWb.aluOut   <= exMem.aluOut;
		memWb.readData <= dmemRd;
	end

	// load data or alu result
	assign wbResult = memWb.memToReg ? memWb.readData : memWb.aluOut;

	// store address comes out of the alu, so check it here
	storeAligned: assert property (@(posedge clk) disable iff (rst)
		dmemWe |-> dmemAddr[1:0] == 2'b00)
		else $error("misaligned store to %h", dmemAddr);

endmodule

// ==== hdl/hazardUnit.sv ====
// purely combinational; memory-stage result preferred over writeback
// loads are never forwarded from ex/mem, the stall covers them
`timescale 1ns/1ps

module hazardUnit (
	input  logic [4:0]     rs1,
	input  logic [4:0]     rs2,
	input  logic           usesBranchOperands,
	input  logic           redirect,
	input  rvPkg::idExT    idEx,
	input  rvPkg::exMemT   exMem,
	input  rvPkg::memWbT   memWb,
	output logic           stallFetch,
	output logic           stallDecode,
	output logic           flushDecode,
	output logic           flushExecute,
	output rvPkg::fwdSelT  fwdA,
	output rvPkg::fwdSelT  fwdB,
	output logic           fwdDecA,
	output logic           fwdDecB
);
	import rvPkg::*;

	logic loadUse, branchWait, stall;

	// x0 never matches
	function automatic logic hits(input logic [4:0] rd, input logic [4:0] rs);
		return (rd != 5'd0) && (rd == rs);
	endfunction

	function automatic fwdSelT pickFwd(input logic [4:0] rs, input exMemT em, input memWbT mw);
		if (em.regWrite && hits(em.rd, rs)) return FwdMem;
		if (mw.regWrite && hits(mw.rd, rs)) return FwdWb;
		return FwdReg;
	endfunction

	// load in execute feeding decode
	assign loadUse = idEx.memToReg && (hits(idEx.rd, rs1) || hits(idEx.rd, rs2));

	// branch compare needs values one stage earlier than the alu
	assign branchWait = usesBranchOperands &&
		((idEx.regWrite && (hits(idEx.rd, rs1) || hits(idEx.rd, rs2))) ||
		(exMem.memToReg && (hits(exMem.rd, rs1) || hits(exMem.rd, rs2))));

	assign stall        = loadUse || branchWait;
	assign stallFetch   = stall;
	assign stallDecode  = stall;
	assign flushExecute = stall;
	assign flushDecode  = redirect && !stall;

	assign fwdA    = pickFwd(idEx.rs1, exMem, memWb);
	assign fwdB    = pickFwd(idEx.rs2, exMem, memWb);
	assign fwdDecA = exMem.regWrite && !exMem.memToReg && hits(exMem.rd, rs1);
	assign fwdDecB = exMem.regWrite && !exMem.memToReg && hits(exMem.rd, rs2);

endmodule

// ==== hdl/riscvPipe.sv ====
// five-stage in-order core for a reduced RV32I subset
// both memories must respond combinationally; there is no handshake
`timescale 1ns/1ps

module riscvPipe (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output logic        dmemWe,
	output logic [31:0] dmemAddr,
	output logic [31:0] dmemWd,
	input  logic [31:0] dmemRd
);
	import rvPkg::*;

	// stage registers
	ifIdT  ifId;
	idExT  idEx;
	exMemT exMem;
	memWbT memWb;

	// feedback nets
	logic [31:0] wbResult;
	logic [31:0] redirectPc;
	logic        redirect;
	logic [4:0]  rs1, rs2;
	logic        usesBranchOperands;

	// hazard controls
	logic   stallFetch, stallDecode, flushDecode, flushExecute;
	logic   fwdDecA, fwdDecB;
	fwdSelT fwdA, fwdB;

	fetchStage fetchStage_i (
		.clk(clk), .rst(rst),
		.stall(stallFetch), .flush(flushDecode),
		.redirect(redirect), .redirectPc(redirectPc),
		.imemData(imemData), .imemAddr(imemAddr),
		.ifId(ifId)
	);

	decodeStage decodeStage_i (
		.clk(clk), .rst(rst),
		.ifId(ifId),
		.stall(stallDecode), .flush(flushExecute),
		.fwdDecA(fwdDecA), .fwdDecB(fwdDecB),
		.exMemAluOut(exMem.aluOut),
		.memWb(memWb), .wbResult(wbResult),
		.rs1(rs1), .rs2(rs2),
		.usesBranchOperands(usesBranchOperands),
		.redirect(redirect), .redirectPc(redirectPc),
		.idEx(idEx)
	);

	executeStage executeStage_i (
		.clk(clk), .rst(rst),
		.idEx(idEx),
		.fwdA(fwdA), .fwdB(fwdB),
		.wbResult(wbResult),
		.exMem(exMem)
	);

	memoryStage memoryStage_i (
		.clk(clk), .rst(rst),
		.exMem(exMem), .dmemRd(dmemRd),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWd(dmemWd),
		.memWb(memWb), .wbResult(wbResult)
	);

	hazardUnit hazardUnit_i (
		.rs1(rs1), .rs2(rs2),
		.usesBranchOperands(usesBranchOperands),
		.redirect(redirect),
		.idEx(idEx), .exMem(exMem), .memWb(memWb),
		.stallFetch(stallFetch), .stallDecode(stallDecode),
		.flushDecode(flushDecode), .flushExecute(flushExecute),
		.fwdA(fwdA), .fwdB(fwdB),
		.fwdDecA(fwdDecA), .fwdDecB(fwdDecB)
	);

endmodule

// ==== verification/riscvPipeTb.sv ====
// fixed program with LFSR immediates; every store is checked against an ISA-level model
// both memories are 64 words and wrap; the program ends in a jal-to-self loop
`timescale 1ns/1ps

module riscvPipeTb;
	import rvPkg::*;

	// one predicted store and the test section it belongs to
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [2:0]  test;
	} storeT;

	logic        clk, rst;
	logic [31:0] imemAddr, imemData, dmemAddr, dmemWd, dmemRd;
	logic        dmemWe;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	logic [2:0]  secOf [64];
	string       testName [6] = '{"reset", "aluChain", "loadUse", "branch", "jump", "upperImm"};
	int          testErr [6];
	int          testStores [6];
	storeT       expQ [$];

	logic [31:0] lfsrState, haltInstr;
	logic [31:0] headAddr, headData, curAddr, curData;
	logic [2:0]  headTest, curSec;
	logic        headValid, popPending, done;
	int          progLen, cycles, limit, errCount, checked, failedTests;

	riscvPipe riscvPipe_i (
		.clk(clk), .rst(rst),
		.imemAddr(imemAddr), .imemData(imemData),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemWd(dmemWd), .dmemRd(dmemRd)
	);

	// both memories answer in the same cycle
	assign imemData = rom[imemAddr[7:2]];
	assign dmemRd   = ram[dmemAddr[7:2]];

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// instruction formats from the ISA manual
	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OpOp};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input opcodeT op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// sw with x0 as base, so the offset is the address
	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OpStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
		input opcodeT op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
	endfunction

	task automatic emit(input logic [31:0] ins);
		rom[progLen]   = ins;
		secOf[progLen] = curSec;
		progLen++;
	endtask

	// unused rom words are distinct no-ops, ram words carry their own address
	task automatic fillMemories();
		for (int i = 0; i < 64; i++) begin
			rom[i]   = iType(12'(4 * i), 5'd0, 3'b000, 5'd0, OpOpImm);
			ram[i]   = {16'hc0de ^ 16'(i), 16'(4 * i)};
			secOf[i] = 3'd0;
		end
	endtask

	task automatic buildProgram();
		progLen   = 0;
		haltInstr = jType(21'd0, 5'd0);
		// back-to-back dependencies through every alu function
		curSec = 3'd1;
		emit(iType(12'(drawBits(12)), 5'd0, 3'b000, 5'd1, OpOpImm));
		emit(iType(12'(drawBits(12)), 5'd1, 3'b000, 5'd2, OpOpImm));
		emit(iType(12'(drawBits(12)), 5'd1, 3'b010, 5'd3, OpOpImm));
		emit(iType(12'(drawBits(12)), 5'd2, 3'b100, 5'd4, OpOpImm));
		emit(iType(12'(drawBits(12)), 5'd4, 3'b110, 5'd5, OpOpImm));
		emit(iType(12'(drawBits(12)), 5'd5, 3'b111, 5'd6, OpOpImm));
		emit(iType({7'h00, 5'(drawBits(5))}, 5'd6, 3'b001, 5'd7, OpOpImm));
		emit(iType({7'h00, 5'(drawBits(5))}, 5'd7, 3'b101, 5'd8, OpOpImm));
		emit(iType({7'h20, 5'(drawBits(5))}, 5'd1, 3'b101, 5'd9, OpOpImm));
		emit(rType(7'h00, 5'd8, 5'd9, 3'b000, 5'd10));
		emit(rType(7'h20, 5'd2, 5'd10, 3'b000, 5'd11));
		emit(rType(7'h00, 5'd1, 5'd11, 3'b010, 5'd12));
		emit(rType(7'h00, 5'd10, 5'd11, 3'b100, 5'd13));
		emit(rType(7'h00, 5'd12, 5'd13, 3'b110, 5'd14));
		emit(rType(7'h00, 5'd11, 5'd14, 3'b111, 5'd15));
		emit(rType(7'h00, 5'd7, 5'd15, 3'b001, 5'd16));
		emit(rType(7'h00, 5'd1, 5'd16, 3'b101, 5'd17));
		emit(rType(7'h20, 5'd13, 5'd11, 3'b101, 5'd18));
		emit(sType(12'd0, 5'd3));
		emit(sType(12'd4, 5'd12));
		emit(sType(12'd8, 5'd17));
		emit(sType(12'd12, 5'd18));
		// store, load back, use at once
		curSec = 3'd2;
		emit(sType(12'd64, 5'd17));
		emit(iType(12'd64, 5'd0, 3'b010, 5'd19, OpLoad));
		emit(rType(7'h00, 5'd1, 5'd19, 3'b000, 5'd20));
		emit(sType(12'd68, 5'd20));
		// taken beq on a fresh result skips a store, bne falls through
		curSec = 3'd3;
		emit(iType(12'(drawBits(12)), 5'd0, 3'b000, 5'd21, OpOpImm));
		emit(bType(13'd8, 5'd21, 5'd21, 3'b000));
		emit(sType(12'd72, 5'd21));
		emit(sType(12'd76, 5'd20));
		emit(bType(13'd8, 5'd1, 5'd1, 3'b001));
		emit(sType(12'd80, 5'd21));
		// jal over a store, jalr with odd target, then writes to x0
		curSec = 3'd4;
		emit(jType(21'd8, 5'd22));
		emit(sType(12'd84, 5'd1));
		emit(sType(12'd88, 5'd22));
		emit(iType(12'(4 * (progLen + 3)), 5'd0, 3'b000, 5'd23, OpOpImm));
		emit(iType(12'd1, 5'd23, 3'b000, 5'd24, OpJalr));
		emit(sType(12'd84, 5'd23));
		emit(sType(12'd92, 5'd24));
		emit(iType(12'(drawBits(12)), 5'd1, 3'b000, 5'd0, OpOpImm));
		emit(jType(21'd4, 5'd0));
		emit(sType(12'd96, 5'd0));
		curSec = 3'd5;
		emit(uType(20'(drawBits(20)), 5'd25, OpLui));
		emit(uType(20'(drawBits(20)), 5'd26, OpAuipc));
		emit(sType(12'd100, 5'd25));
		emit(sType(12'd104, 5'd26));
		emit(haltInstr);
	endtask

	// register-register and register-immediate results per the ISA
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101: begin
				if (alt) return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// instruction-level model, runs the rom once and queues every store
	task automatic runModel();
		logic [31:0] xr [32];
		logic [31:0] dm [64];
		logic [31:0] pc, ins, a, b, res, nextPc, addr;
		logic [31:0] immI, immS, immB, immU, immJ;
		logic        wr;
		int          steps;
		for (int i = 0; i < 32; i++) xr[i] = 32'd0;
		for (int i = 0; i < 64; i++) dm[i] = ram[i];
		pc    = ResetPc;
		steps = 0;
		while (rom[pc[7:2]] != haltInstr && steps < 500) begin
			ins    = rom[pc[7:2]];
			a      = xr[ins[19:15]];
			b      = xr[ins[24:20]];
			immI   = {{20{ins[31]}}, ins[31:20]};
			immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			immB   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			immU   = {ins[31:12], 12'd0};
			immJ   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			nextPc = pc + 32'd4;
			wr     = 1'b1;
			res    = 32'd0;
			case (ins[6:0])
				OpLui:   res = immU;
				OpAuipc: res = pc + immU;
				OpJal: begin
					res    = pc + 32'd4;
					nextPc = pc + immJ;
				end
				OpJalr: begin
					res    = pc + 32'd4;
					nextPc = (a + immI) & ~32'd1;
				end
				OpBranch: begin
					wr = 1'b0;
					if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b))
						nextPc = pc + immB;
				end
				OpLoad: begin
					addr = a + immI;
					res  = dm[addr[7:2]];
				end
				OpStore: begin
					wr   = 1'b0;
					addr = a + immS;
					dm[addr[7:2]] = b;
					expQ.push_back(storeT'{addr: addr, data: b, test: secOf[pc[7:2]]});
					testStores[secOf[pc[7:2]]]++;
				end
				OpOpImm: res = refAlu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
				OpOp:    res = refAlu(ins[14:12], ins[30], a, b);
				default: wr = 1'b0;
			endcase
			if (wr && ins[11:7] != 5'd0) xr[ins[11:7]] = res;
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic loadHead();
		headValid = (expQ.size() > 0);
		if (headValid) begin
			headAddr = expQ[0].addr;
			headData = expQ[0].data;
			headTest = expQ[0].test;
		end
	endtask

	// a section is done when its last predicted store has been seen
	task automatic retireStore();
		storeT s;
		if (expQ.size() > 0) begin
			s = expQ.pop_front();
			checked++;
			if (expQ.size() == 0 || expQ[0].test != s.test)
				$display("test %-8s %0d stores, %0d errors", testName[s.test],
					testStores[s.test], testErr[s.test]);
		end
	endtask

	// out of reset the first fetch is ResetPc and nothing is stored
	resetPc: assert property (@(posedge clk) $fell(rst) |-> imemAddr == ResetPc)
		else begin
			$display("FAILED %s first fetch: expected %h, actual %h", testName[0], ResetPc,
				$sampled(imemAddr));
			testErr[0]++;
			errCount++;
		end

	resetQuiet: assert property (@(posedge clk) $fell(rst) |-> !dmemWe)
		else begin
			$display("store strobe was high in the first cycle after reset");
			testErr[0]++;
			errCount++;
		end

	// each strobe must match the next store the model predicts
	extraStore: assert property (@(posedge clk) disable iff (rst) dmemWe |-> headValid)
		else begin
			$display("unexpected store to %h after all predicted stores", curAddr);
			errCount++;
		end

	storeAddr: assert property (@(posedge clk) disable iff (rst)
		(dmemWe && headValid) |-> dmemAddr == headAddr)
		else begin
			$display("FAILED %s store address: expected %h, actual %h", testName[headTest],
				headAddr, curAddr);
			testErr[headTest]++;
			errCount++;
		end

	storeData: assert property (@(posedge clk) disable iff (rst)
		(dmemWe && headValid) |-> dmemWd == headData)
		else begin
			$display("FAILED %s store data at %h: expected %h, actual %h", testName[headTest],
				headAddr, headData, curData);
			testErr[headTest]++;
			errCount++;
		end

	initial begin
		rst        = 1'b1;
		lfsrState  = 32'h2e05d345;
		errCount   = 0;
		checked    = 0;
		cycles     = 0;
		headValid  = 1'b0;
		headAddr   = 32'd0;
		headData   = 32'd0;
		headTest   = 3'd0;
		curAddr    = 32'd0;
		curData    = 32'd0;
		popPending = 1'b0;
		done       = 1'b0;
		fillMemories();
		buildProgram();
		runModel();
		limit = 3 * progLen + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// a store strobed now is compared at the next rising edge
		while (!done && cycles < limit) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1)
				$display("test %-8s first fetch and data port, %0d errors", testName[0],
					testErr[0]);
			if (popPending) retireStore();
			loadHead();
			popPending = dmemWe;
			curAddr    = dmemAddr;
			curData    = dmemWd;
			if (dmemWe) ram[dmemAddr[7:2]] = dmemWd;
			done = (expQ.size() == 0) && !popPending;
		end
		if (!done) begin
			$display("program never finished: %0d stores still expected after %0d cycles",
				expQ.size(), cycles);
			$display("** FAIL **");
		end else begin
			// a few idle cycles to catch stray stores past the end
			repeat (4) @(negedge clk);
			failedTests = 0;
			for (int i = 0; i < 6; i++) begin
				if (testErr[i] != 0) failedTests++;
			end
			$display("6 tests, %0d failed, %0d stores checked, %0d errors", failedTests,
				checked, errCount);
			if (errCount == 0)
				$display("** PASS **");
			else
				$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== riscvPipe.f ====
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/riscvPipe.sv
verification/riscvPipeTb.sv
